// File: mul_pkg.sv
package mul_pkg;

	// Operand and product widths
	localparam int MPLIER_W = 7;
	localparam int MCAND_W  = 9;
	localparam int PROD_W   = 16;

	// Widest selected multiple is 4Y of a 9-bit value
	localparam int MULT_W = 11;

	// Radix-8 digits for a 7-bit multiplier
	localparam int NUM_DIGITS = 3;

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite register map

	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;

	localparam logic [AXI_ADDR_W-1:0] ADDR_OPERAND = 4'h0;
	localparam logic [AXI_ADDR_W-1:0] ADDR_PRODUCT = 4'h4;

	// Field positions inside the operand word
	localparam int OPER_MPLIER_LSB = 0;
	localparam int OPER_MCAND_LSB  = 16;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: ks_adder.sv
`timescale 1ns/100ps

module ks_adder #(
	parameter int WIDTH = 16
) (
	input  logic [WIDTH-1:0] i_a,
	input  logic [WIDTH-1:0] i_b,
	input  logic             i_cin,
	output logic [WIDTH-1:0] o_sum,
	output logic             o_cout
);

	localparam int STAGES = $clog2(WIDTH);

	logic [WIDTH-1:0] prop_bit;
	logic [WIDTH:0]   carry;

	// Group generate and propagate after each prefix stage
	wire  [WIDTH-1:0] grp_g [0:STAGES];
	wire  [WIDTH-1:0] grp_p [0:STAGES];

	assign prop_bit = i_a ^ i_b;
	assign grp_p[0] = prop_bit;

	// Carry-in folds into bit 0 as an extra generate term
	for (genvar i = 0; i < WIDTH; i++) begin : g_bit
		if (i == 0) begin : g_lsb
			assign grp_g[0][i] = (i_a[i] & i_b[i]) | (prop_bit[i] & i_cin);
		end else begin : g_upper
			assign grp_g[0][i] = i_a[i] & i_b[i];
		end
	end

	for (genvar s = 0; s < STAGES; s++) begin : g_stage
		for (genvar i = 0; i < WIDTH; i++) begin : g_node
			if (i >= (1 << s)) begin : g_black
				assign grp_g[s+1][i] = grp_g[s][i] | (grp_p[s][i] & grp_g[s][i-(1<<s)]);
				assign grp_p[s+1][i] = grp_p[s][i] & grp_p[s][i-(1<<s)];
			end else begin : g_pass
				// group already reaches bit 0
				assign grp_g[s+1][i] = grp_g[s][i];
				assign grp_p[s+1][i] = grp_p[s][i];
			end
		end
	end

	assign carry  = {grp_g[STAGES], i_cin};
	assign o_sum  = prop_bit ^ carry[WIDTH-1:0];
	assign o_cout = carry[WIDTH];

endmodule

// File: booth_multiple_gen.sv
`timescale 1ns/100ps

module booth_multiple_gen (
	input  logic [mul_pkg::MCAND_W-1:0] i_mcand,
	output logic [mul_pkg::MULT_W-1:0]  o_y,
	output logic [mul_pkg::MULT_W-1:0]  o_y2,
	output logic [mul_pkg::MULT_W-1:0]  o_y3,
	output logic [mul_pkg::MULT_W-1:0]  o_y4
);

	localparam int PAD_W = mul_pkg::MULT_W - mul_pkg::MCAND_W;

	// Easy multiples by shifting
	assign o_y  = {{PAD_W{1'b0}}, i_mcand};
	assign o_y2 = {{(PAD_W-1){1'b0}}, i_mcand, 1'b0};
	assign o_y4 = {i_mcand, 2'b00};

	// 3Y fits in MULT_W so the carry-out stays zero
	ks_adder #(
		.WIDTH (mul_pkg::MULT_W)
	) u_add_3y (
		.i_a    (o_y),
		.i_b    (o_y2),
		.i_cin  (1'b0),
		.o_sum  (o_y3),
		.o_cout ()
	);

endmodule

// File: booth_pp_gen.sv
`timescale 1ns/100ps

module booth_pp_gen (
	input  logic [3:0]                 i_window,
	input  logic [mul_pkg::MULT_W-1:0] i_y,
	input  logic [mul_pkg::MULT_W-1:0] i_y2,
	input  logic [mul_pkg::MULT_W-1:0] i_y3,
	input  logic [mul_pkg::MULT_W-1:0] i_y4,
	output logic [mul_pkg::MULT_W-1:0] o_pp,
	output logic                       o_neg
);

	logic                       sel_1;
	logic                       sel_2;
	logic                       sel_3;
	logic                       sel_4;
	logic                       sign;
	logic [mul_pkg::MULT_W-1:0] mag;

	// Digit = -4*w[3] + 2*w[2] + w[1] + w[0]
	always_comb begin
		sel_1 = 1'b0;
		sel_2 = 1'b0;
		sel_3 = 1'b0;
		sel_4 = 1'b0;
		case (i_window)
			4'b0001, 4'b0010, 4'b1101, 4'b1110: sel_1 = 1'b1;
			4'b0011, 4'b0100, 4'b1011, 4'b1100: sel_2 = 1'b1;
			4'b0101, 4'b0110, 4'b1001, 4'b1010: sel_3 = 1'b1;
			4'b0111, 4'b1000:                   sel_4 = 1'b1;
			// 0000 and 1111 select nothing
			default: ;
		endcase
	end

	assign sign = i_window[3];

	assign mag = ({mul_pkg::MULT_W{sel_1}} & i_y)
		| ({mul_pkg::MULT_W{sel_2}} & i_y2)
		| ({mul_pkg::MULT_W{sel_3}} & i_y3)
		| ({mul_pkg::MULT_W{sel_4}} & i_y4);

	// One's complement here, the +1 goes into the tree
	assign o_pp  = mag ^ {mul_pkg::MULT_W{sign}};
	assign o_neg = sign;

endmodule

// File: csa_tree.sv
`timescale 1ns/100ps

module csa_tree (
	input  logic [mul_pkg::MULT_W-1:0] i_pp0,
	input  logic [mul_pkg::MULT_W-1:0] i_pp1,
	input  logic [mul_pkg::MULT_W-1:0] i_pp2,
	input  logic                       i_neg0,
	input  logic                       i_neg1,
	input  logic                       i_neg2,
	output logic [mul_pkg::PROD_W-1:0] o_row_sum,
	output logic [mul_pkg::PROD_W-1:0] o_row_carry
);

	localparam int PW = mul_pkg::PROD_W;

	logic [PW-1:0] row0;
	logic [PW-1:0] row1;
	logic [PW-1:0] row2;
	// Carry passed sideways from column i into column i+1
	logic [PW-2:6] chain;

	function automatic logic [1:0] comp_3to2(input logic a, input logic b, input logic c);
		comp_3to2 = {(a & b) | (a & c) | (b & c), a ^ b ^ c};
	endfunction

	function automatic logic [1:0] comp_2to2(input logic a, input logic b);
		comp_2to2 = {a & b, a ^ b};
	endfunction

	// Returns cout, carry and sum; cout never depends on cin
	function automatic logic [2:0] comp_4to2(input logic a, input logic b, input logic c,
		input logic d, input logic cin);
		logic [1:0] first;
		logic [1:0] second;
		first     = comp_3to2(a, b, c);
		second    = comp_3to2(first[0], d, cin);
		comp_4to2 = {first[1], second};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Partial products with sign extension prevention
	assign row0 = {1'b0, ~i_neg0, {3{i_neg0}}, i_pp0};
	assign row1 = {1'b1, ~i_neg1, i_pp1, 3'b000};
	// Top bit of pp2 falls above the product
	assign row2 = PW'({i_pp2, 6'b000000});

	always_comb begin
		o_row_sum   = '0;
		o_row_carry = '0;
		o_row_sum[2:0] = row0[2:0];
		// Empty carry slot at column 0 takes neg0
		o_row_carry[0] = i_neg0;
		{o_row_carry[4], o_row_sum[3]} = comp_3to2(row0[3], row1[3], i_neg1);
		{o_row_carry[5], o_row_sum[4]} = comp_2to2(row0[4], row1[4]);
		{o_row_carry[6], o_row_sum[5]} = comp_2to2(row0[5], row1[5]);
		{chain[6], o_row_carry[7], o_row_sum[6]} =
			comp_4to2(row0[6], row1[6], row2[6], i_neg2, 1'b0);
		for (int i = 7; i < PW - 1; i++) begin
			{chain[i], o_row_carry[i+1], o_row_sum[i]} =
				comp_4to2(row0[i], row1[i], row2[i], 1'b0, chain[i-1]);
		end
		// Carries out of the top column are dropped
		o_row_sum[PW-1] = row0[PW-1] ^ row1[PW-1] ^ row2[PW-1] ^ chain[PW-2];
	end

endmodule

// File: booth_mul_core.sv
`timescale 1ns/100ps

module booth_mul_core #(
	parameter int MPLIER_W = mul_pkg::MPLIER_W,
	parameter int MCAND_W  = mul_pkg::MCAND_W,
	parameter int PROD_W   = mul_pkg::PROD_W
) (
	input  logic [MPLIER_W-1:0] i_mplier,
	input  logic [MCAND_W-1:0]  i_mcand,
	output logic [PROD_W-1:0]   o_product
);

	localparam int ND    = mul_pkg::NUM_DIGITS;
	localparam int EXT_W = 3 * ND + 1;

	logic [mul_pkg::MULT_W-1:0] mult_y;
	logic [mul_pkg::MULT_W-1:0] mult_y2;
	logic [mul_pkg::MULT_W-1:0] mult_y3;
	logic [mul_pkg::MULT_W-1:0] mult_y4;
	logic [EXT_W-1:0]           mplier_ext;
	logic [mul_pkg::MULT_W-1:0] pp [ND];
	logic [ND-1:0]              neg;
	logic [PROD_W-1:0]          row_sum;
	logic [PROD_W-1:0]          row_carry;

	booth_multiple_gen u_mult (
		.i_mcand (i_mcand),
		.o_y     (mult_y),
		.o_y2    (mult_y2),
		.o_y3    (mult_y3),
		.o_y4    (mult_y4)
	);

	// Zero below bit 0, zero padding above the top bit
	assign mplier_ext = {{(EXT_W - MPLIER_W - 1){1'b0}}, i_mplier, 1'b0};

	for (genvar k = 0; k < ND; k++) begin : g_digit
		booth_pp_gen u_pp (
			.i_window (mplier_ext[3*k +: 4]),
			.i_y      (mult_y),
			.i_y2     (mult_y2),
			.i_y3     (mult_y3),
			.i_y4     (mult_y4),
			.o_pp     (pp[k]),
			.o_neg    (neg[k])
		);
	end

	csa_tree u_tree (
		.i_pp0       (pp[0]),
		.i_pp1       (pp[1]),
		.i_pp2       (pp[2]),
		.i_neg0      (neg[0]),
		.i_neg1      (neg[1]),
		.i_neg2      (neg[2]),
		.o_row_sum   (row_sum),
		.o_row_carry (row_carry)
	);

	ks_adder #(
		.WIDTH (PROD_W)
	) u_cpa (
		.i_a    (row_sum),
		.i_b    (row_carry),
		.i_cin  (1'b0),
		.o_sum  (o_product),
		.o_cout ()
	);

endmodule

// File: axil_mul_regs.sv
`timescale 1ns/100ps

module axil_mul_regs #(
	parameter int MPLIER_W = mul_pkg::MPLIER_W,
	parameter int MCAND_W  = mul_pkg::MCAND_W,
	parameter int PROD_W   = mul_pkg::PROD_W
) (
	input  logic                              i_clk,
	input  logic                              i_rst_n,
	input  logic                              i_awvalid,
	input  logic [mul_pkg::AXI_ADDR_W-1:0]    i_awaddr,
	output logic                              o_awready,
	input  logic                              i_wvalid,
	input  logic [mul_pkg::AXI_DATA_W-1:0]    i_wdata,
	input  logic [mul_pkg::AXI_DATA_W/8-1:0]  i_wstrb,
	output logic                              o_wready,
	output logic                              o_bvalid,
	output logic [1:0]                        o_bresp,
	input  logic                              i_bready,
	input  logic                              i_arvalid,
	input  logic [mul_pkg::AXI_ADDR_W-1:0]    i_araddr,
	output logic                              o_arready,
	output logic                              o_rvalid,
	output logic [mul_pkg::AXI_DATA_W-1:0]    o_rdata,
	output logic [1:0]                        o_rresp,
	input  logic                              i_rready,
	output logic [MPLIER_W-1:0]               o_mplier,
	output logic [MCAND_W-1:0]                o_mcand,
	input  logic [PROD_W-1:0]                 i_product
);

	localparam int DATA_W = mul_pkg::AXI_DATA_W;

	logic [MPLIER_W-1:0] mplier_q;
	logic [MCAND_W-1:0]  mcand_q;
	logic [PROD_W-1:0]   product_q;
	logic [DATA_W-1:0]   oper_word;
	logic [DATA_W-1:0]   oper_merged;

	logic        wr_ready_q;
	logic        wr_fire;
	logic        wr_addr_ok;
	logic        wr_done_q;
	logic        bvalid_q;
	logic [1:0]  bresp_q;

	logic              arready_q;
	logic              rd_fire;
	logic              rvalid_d;
	logic              rvalid_q;
	logic [DATA_W-1:0] rdata_d;
	logic [DATA_W-1:0] rdata_q;
	logic [1:0]        rresp_d;
	logic [1:0]        rresp_q;

	// Stored fields as seen on the bus, unused bits read 0
	assign oper_word = (DATA_W'(mplier_q) << mul_pkg::OPER_MPLIER_LSB)
		| (DATA_W'(mcand_q) << mul_pkg::OPER_MCAND_LSB);

	//////////////////////////////////////////////////////////////////////
	// Write path

	assign wr_fire    = wr_ready_q & i_awvalid & i_wvalid;
	assign wr_addr_ok = (i_awaddr == mul_pkg::ADDR_OPERAND);

	always_comb begin
		for (int b = 0; b < DATA_W / 8; b++) begin
			oper_merged[8*b +: 8] = i_wstrb[b] ? i_wdata[8*b +: 8] : oper_word[8*b +: 8];
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_ready_q <= 1'b0;
			wr_done_q  <= 1'b0;
			bvalid_q   <= 1'b0;
		end else begin
			// Single-cycle ready, never while a response is owed
			wr_ready_q <= i_awvalid & i_wvalid & ~wr_ready_q & ~wr_done_q & ~bvalid_q;
			wr_done_q  <= wr_fire;
			if (wr_done_q) begin
				bvalid_q <= 1'b1;
			end else if (i_bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_fire) begin
			bresp_q <= wr_addr_ok ? mul_pkg::RESP_OKAY : mul_pkg::RESP_SLVERR;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			mplier_q <= '0;
			mcand_q  <= '0;
		end else if (wr_fire && wr_addr_ok) begin
			mplier_q <= oper_merged[mul_pkg::OPER_MPLIER_LSB +: MPLIER_W];
			mcand_q  <= oper_merged[mul_pkg::OPER_MCAND_LSB +: MCAND_W];
		end
	end

	// Product settles one cycle behind the operands
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			product_q <= '0;
		end else if (wr_done_q && (bresp_q == mul_pkg::RESP_OKAY)) begin
			product_q <= i_product;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read path

	assign rd_fire  = arready_q & i_arvalid;
	assign rvalid_d = rd_fire | (rvalid_q & ~i_rready);

	always_comb begin
		rdata_d = '0;
		rresp_d = mul_pkg::RESP_OKAY;
		case (i_araddr)
			mul_pkg::ADDR_OPERAND: rdata_d = oper_word;
			mul_pkg::ADDR_PRODUCT: rdata_d = DATA_W'(product_q);
			default:               rresp_d = mul_pkg::RESP_SLVERR;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end else begin
			arready_q <= ~rvalid_d;
			rvalid_q  <= rvalid_d;
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd_fire) begin
			rdata_q <= rdata_d;
			rresp_q <= rresp_d;
		end
	end

	assign o_awready = wr_ready_q;
	assign o_wready  = wr_ready_q;
	assign o_bvalid  = bvalid_q;
	assign o_bresp   = bresp_q;
	assign o_arready = arready_q;
	assign o_rvalid  = rvalid_q;
	assign o_rdata   = rdata_q;
	assign o_rresp   = rresp_q;
	assign o_mplier  = mplier_q;
	assign o_mcand   = mcand_q;

endmodule

// File: mul_axil_top.sv
`timescale 1ns/100ps

module mul_axil_top (
	input  logic                              i_clk,
	input  logic                              i_rst_n,
	input  logic                              i_awvalid,
	input  logic [mul_pkg::AXI_ADDR_W-1:0]    i_awaddr,
	output logic                              o_awready,
	input  logic                              i_wvalid,
	input  logic [mul_pkg::AXI_DATA_W-1:0]    i_wdata,
	input  logic [mul_pkg::AXI_DATA_W/8-1:0]  i_wstrb,
	output logic                              o_wready,
	output logic                              o_bvalid,
	output logic [1:0]                        o_bresp,
	input  logic                              i_bready,
	input  logic                              i_arvalid,
	input  logic [mul_pkg::AXI_ADDR_W-1:0]    i_araddr,
	output logic                              o_arready,
	output logic                              o_rvalid,
	output logic [mul_pkg::AXI_DATA_W-1:0]    o_rdata,
	output logic [1:0]                        o_rresp,
	input  logic                              i_rready
);

	logic [mul_pkg::MPLIER_W-1:0] mplier;
	logic [mul_pkg::MCAND_W-1:0]  mcand;
	logic [mul_pkg::PROD_W-1:0]   product;

	axil_mul_regs #(
		.MPLIER_W (mul_pkg::MPLIER_W),
		.MCAND_W  (mul_pkg::MCAND_W),
		.PROD_W   (mul_pkg::PROD_W)
	) u_regs (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_awvalid (i_awvalid),
		.i_awaddr  (i_awaddr),
		.o_awready (o_awready),
		.i_wvalid  (i_wvalid),
		.i_wdata   (i_wdata),
		.i_wstrb   (i_wstrb),
		.o_wready  (o_wready),
		.o_bvalid  (o_bvalid),
		.o_bresp   (o_bresp),
		.i_bready  (i_bready),
		.i_arvalid (i_arvalid),
		.i_araddr  (i_araddr),
		.o_arready (o_arready),
		.o_rvalid  (o_rvalid),
		.o_rdata   (o_rdata),
		.o_rresp   (o_rresp),
		.i_rready  (i_rready),
		.o_mplier  (mplier),
		.o_mcand   (mcand),
		.i_product (product)
	);

	// Purely combinational multiplier between the registers
	booth_mul_core #(
		.MPLIER_W (mul_pkg::MPLIER_W),
		.MCAND_W  (mul_pkg::MCAND_W),
		.PROD_W   (mul_pkg::PROD_W)
	) u_core (
		.i_mplier  (mplier),
		.i_mcand   (mcand),
		.o_product (product)
	);

endmodule

// File: axil_mul_checker.sv
`timescale 1ns/100ps

module axil_mul_checker (
	input logic                           i_clk,
	input logic                           i_rst_n,
	input logic                           i_awready,
	input logic                           i_wready,
	input logic                           i_bvalid,
	input logic [1:0]                     i_bresp,
	input logic                           i_bready,
	input logic                           i_arready,
	input logic                           i_rvalid,
	input logic [mul_pkg::AXI_DATA_W-1:0] i_rdata,
	input logic [1:0]                     i_rresp,
	input logic                           i_rready
);

	// Counts failed assertions for the testbench
	int fail_count = 0;

	//////////////////////////////////////////////////////////////////////
	// Reset behaviour

	a_reset_quiet: assert property (@(posedge i_clk)
		!i_rst_n |=> !(i_awready | i_wready | i_arready | i_bvalid | i_rvalid))
	else begin
		fail_count++;
		$error("Handshake output high after a reset cycle");
	end

	//////////////////////////////////////////////////////////////////////
	// Response channels hold under back-pressure

	a_b_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
	else begin
		fail_count++;
		$error("Write response changed before bready");
	end

	a_r_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
	else begin
		fail_count++;
		$error("Read response changed before rready");
	end

	// No new write while a response is owed
	a_aw_blocked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_awready && i_bvalid))
	else begin
		fail_count++;
		$error("awready high with bvalid pending");
	end

endmodule

bind axil_mul_regs axil_mul_checker u_checker (
	.i_clk     (i_clk),
	.i_rst_n   (i_rst_n),
	.i_awready (o_awready),
	.i_wready  (o_wready),
	.i_bvalid  (o_bvalid),
	.i_bresp   (o_bresp),
	.i_bready  (i_bready),
	.i_arready (o_arready),
	.i_rvalid  (o_rvalid),
	.i_rdata   (o_rdata),
	.i_rresp   (o_rresp),
	.i_rready  (i_rready)
);

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
	end

	// Free running, half period high and half low
	always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: tb_mul_axil_top.sv
`timescale 1ns/100ps

module tb_mul_axil_top;

	localparam int ADDR_W         = mul_pkg::AXI_ADDR_W;
	localparam int DATA_W         = mul_pkg::AXI_DATA_W;
	localparam int STRB_W         = DATA_W / 8;
	localparam int TIMEOUT_CYCLES = 50;
	localparam int NUM_RANDOM     = 200;

	localparam logic [ADDR_W-1:0] ADDR_BAD  = 4'h8;
	localparam logic [STRB_W-1:0] STRB_ALL  = {STRB_W{1'b1}};

	logic              clk;
	logic              rst_n;
	logic              awvalid;
	logic [ADDR_W-1:0] awaddr;
	logic              awready;
	logic              wvalid;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wready;
	logic              bvalid;
	logic [1:0]        bresp;
	logic              bready;
	logic              arvalid;
	logic [ADDR_W-1:0] araddr;
	logic              arready;
	logic              rvalid;
	logic [DATA_W-1:0] rdata;
	logic [1:0]        rresp;
	logic              rready;

	tb_clk_gen #(
		.PERIOD_NS (40)
	) u_clk (
		.o_clk (clk)
	);

	mul_axil_top uut (
		.i_clk     (clk),
		.i_rst_n   (rst_n),
		.i_awvalid (awvalid),
		.i_awaddr  (awaddr),
		.o_awready (awready),
		.i_wvalid  (wvalid),
		.i_wdata   (wdata),
		.i_wstrb   (wstrb),
		.o_wready  (wready),
		.o_bvalid  (bvalid),
		.o_bresp   (bresp),
		.i_bready  (bready),
		.i_arvalid (arvalid),
		.i_araddr  (araddr),
		.o_arready (arready),
		.o_rvalid  (rvalid),
		.o_rdata   (rdata),
		.o_rresp   (rresp),
		.i_rready  (rready)
	);

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
		abort_run();
	endtask

	task automatic check_eq(input string name, input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// Multiplicand at bit 16 and multiplier at bit 0 of the operand word
	function automatic logic [DATA_W-1:0] pack_operands(
		input logic [mul_pkg::MPLIER_W-1:0] mpl,
		input logic [mul_pkg::MCAND_W-1:0]  mcd);
		pack_operands = {7'b0, mcd, 9'b0, mpl};
	endfunction

	// Assertion failures in the bound checker end the run
	always @(negedge clk) begin
		if (uut.u_regs.u_checker.fail_count != 0) begin
			$display("Protocol assertion failed in the AXI checker");
			abort_run();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite channel tasks entered 1 ns after a rising edge

	task automatic axil_write_req(input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		int cycles;
		cycles  = 0;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		while (!(awready && wready)) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				report_timeout("awready and wready");
			end
		end
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
	endtask

	task automatic wait_bvalid();
		int cycles;
		cycles = 0;
		while (!bvalid) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				report_timeout("bvalid");
			end
		end
	endtask

	task automatic axil_write_resp(output logic [1:0] wr_resp);
		bready = 1'b1;
		wait_bvalid();
		wr_resp = bresp;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb, output logic [1:0] wr_resp);
		axil_write_req(addr, data, strb);
		axil_write_resp(wr_resp);
	endtask

	task automatic axil_read_req(input logic [ADDR_W-1:0] addr);
		int cycles;
		cycles  = 0;
		araddr  = addr;
		arvalid = 1'b1;
		while (!arready) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				report_timeout("arready");
			end
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
	endtask

	task automatic wait_rvalid();
		int cycles;
		cycles = 0;
		while (!rvalid) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				report_timeout("rvalid");
			end
		end
	endtask

	task automatic axil_read_resp(output logic [DATA_W-1:0] rd_data, output logic [1:0] rd_resp);
		rready = 1'b1;
		wait_rvalid();
		rd_data = rdata;
		rd_resp = rresp;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rd_data,
		output logic [1:0] rd_resp);
		axil_read_req(addr);
		axil_read_resp(rd_data, rd_resp);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	// Full-word operand write followed by product and operand read-back
	task automatic run_product(input logic [DATA_W-1:0] word);
		logic [mul_pkg::MPLIER_W-1:0] mpl;
		logic [mul_pkg::MCAND_W-1:0]  mcd;
		logic [1:0]                   resp;
		logic [DATA_W-1:0]            data;
		mpl = word[mul_pkg::OPER_MPLIER_LSB +: mul_pkg::MPLIER_W];
		mcd = word[mul_pkg::OPER_MCAND_LSB +: mul_pkg::MCAND_W];
		axil_write(mul_pkg::ADDR_OPERAND, word, STRB_ALL, resp);
		check_eq("bresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		axil_read(mul_pkg::ADDR_PRODUCT, data, resp);
		check_eq("rresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		check_eq("product", data, DATA_W'(mpl) * DATA_W'(mcd));
		axil_read(mul_pkg::ADDR_OPERAND, data, resp);
		check_eq("rresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		check_eq("operand", data, pack_operands(mpl, mcd));
	endtask

	task automatic test_reset_state();
		logic [1:0]        resp;
		logic [DATA_W-1:0] data;
		axil_read(mul_pkg::ADDR_OPERAND, data, resp);
		check_eq("rresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		check_eq("operand", data, '0);
		axil_read(mul_pkg::ADDR_PRODUCT, data, resp);
		check_eq("rresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		check_eq("product", data, '0);
	endtask

	task automatic test_corner_products();
		logic [mul_pkg::MPLIER_W-1:0] mpl [12];
		logic [mul_pkg::MCAND_W-1:0]  mcd [12];
		// Digits of +3, -3, +4 and -4 in the low and middle slices
		mpl = '{7'd0, 7'd127, 7'd3, 7'd4, 7'd5, 7'd24, 7'd28, 7'd40, 7'd96, 7'd127, 7'd0, 7'd85};
		mcd = '{9'd0, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd511, 9'd1,
			9'd511, 9'd170};
		for (int i = 0; i < 12; i++) begin
			run_product(pack_operands(mpl[i], mcd[i]));
		end
	endtask

	task automatic test_random_products();
		// Unused word bits are random too and must read back as 0
		for (int i = 0; i < NUM_RANDOM; i++) begin
			run_product($urandom);
		end
	endtask

	task automatic test_byte_strobes();
		logic [1:0]                  resp;
		logic [DATA_W-1:0]           data;
		logic [mul_pkg::MCAND_W-1:0] mcd_exp;
		run_product(pack_operands(7'd93, 9'h1a5));
		axil_write(mul_pkg::ADDR_OPERAND, 32'hc33c_9669, 4'b0100, resp);
		check_eq("bresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		// Byte 2 replaces only the low multiplicand byte
		mcd_exp = {1'b1, 8'h3c};
		axil_read(mul_pkg::ADDR_OPERAND, data, resp);
		check_eq("operand", data, pack_operands(7'd93, mcd_exp));
		axil_read(mul_pkg::ADDR_PRODUCT, data, resp);
		check_eq("product", data, DATA_W'(93) * DATA_W'(mcd_exp));
	endtask

	task automatic test_error_responses();
		logic [1:0]        resp;
		logic [DATA_W-1:0] data;
		run_product(pack_operands(7'd100, 9'd300));
		axil_write(mul_pkg::ADDR_PRODUCT, 32'hffff_ffff, STRB_ALL, resp);
		check_eq("bresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_SLVERR));
		axil_read(mul_pkg::ADDR_PRODUCT, data, resp);
		check_eq("rresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		check_eq("product", data, DATA_W'(30000));
		axil_write(ADDR_BAD, 32'h1234_5678, STRB_ALL, resp);
		check_eq("bresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_SLVERR));
		axil_read(ADDR_BAD, data, resp);
		check_eq("rresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_SLVERR));
		check_eq("rdata", data, '0);
		axil_read(mul_pkg::ADDR_OPERAND, data, resp);
		check_eq("operand", data, pack_operands(7'd100, 9'd300));
	endtask

	task automatic test_back_pressure();
		logic [1:0]        bresp_seen;
		logic [1:0]        rresp_seen;
		logic [DATA_W-1:0] rdata_seen;
		logic [1:0]        resp;
		logic [DATA_W-1:0] data;
		axil_write_req(mul_pkg::ADDR_OPERAND, pack_operands(7'd117, 9'd433), STRB_ALL);
		wait_bvalid();
		bresp_seen = bresp;
		axil_read_req(mul_pkg::ADDR_PRODUCT);
		wait_rvalid();
		rdata_seen = rdata;
		rresp_seen = rresp;
		check_eq("bresp", DATA_W'(bresp_seen), DATA_W'(mul_pkg::RESP_OKAY));
		check_eq("rdata", rdata_seen, DATA_W'(117) * DATA_W'(433));
		// Both ready inputs stay low for five cycles
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			#1;
			check_eq("bvalid", DATA_W'(bvalid), DATA_W'(1));
			check_eq("bresp", DATA_W'(bresp), DATA_W'(bresp_seen));
			check_eq("rvalid", DATA_W'(rvalid), DATA_W'(1));
			check_eq("rdata", rdata, rdata_seen);
			check_eq("rresp", DATA_W'(rresp), DATA_W'(rresp_seen));
		end
		axil_write_resp(resp);
		check_eq("bresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		axil_read_resp(data, resp);
		check_eq("rresp", DATA_W'(resp), DATA_W'(mul_pkg::RESP_OKAY));
		check_eq("product", data, DATA_W'(117) * DATA_W'(433));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		rst_n   = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		void'($urandom(32'hfc22_13c3));

		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_reset_state();
		test_corner_products();
		test_random_products();
		test_byte_strobes();
		test_error_responses();
		test_back_pressure();

		if (uut.u_regs.u_checker.fail_count != 0) begin
			$display("AXI checker counted %0d assertion failures",
				uut.u_regs.u_checker.fail_count);
			abort_run();
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

// File: filelist.f
mul_pkg.sv
ks_adder.sv
booth_multiple_gen.sv
booth_pp_gen.sv
csa_tree.sv
booth_mul_core.sv
axil_mul_regs.sv
mul_axil_top.sv
axil_mul_checker.sv
tb_clk_gen.sv
tb_mul_axil_top.sv

// File: Makefile
TOP := tb_mul_axil_top
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
